// ==== build.f ====
+incdir+hw
+incdir+test
hw/hs_data_pkg.sv
hw/hs_ctrl_pkg.sv
hw/hs_fifo.sv
hw/hs_xfer_counter.sv
hw/full_handshake_tx.sv
hw/full_handshake_rx.sv
hw/hs_cdc_link.sv
test/tb_hs_cdc_link.sv

// ==== Bender.yml ====
package:
  name: hs_cdc_link

sources:
  - include_dirs:
      - hw
    files:
      - hw/hs_data_pkg.sv
      - hw/hs_ctrl_pkg.sv
      - hw/hs_fifo.sv
      - hw/hs_xfer_counter.sv
      - hw/full_handshake_tx.sv
      - hw/full_handshake_rx.sv
      - hw/hs_cdc_link.sv
  - target: test
    include_dirs:
      - hw
      - test
    files:
      - test/tb_hs_cdc_link.sv

// ==== test/tb_hs_checks.svh ====
/* compare tasks for words, tags, counts and flags, plus the error counters */
`ifndef TB_HS_CHECKS_SVH
`define TB_HS_CHECKS_SVH

int check_total  = 0;
int value_errors = 0;   // wrong values seen
int other_errors = 0;   // timeouts, model mismatches

task automatic check_word(input string name, input hs_data_pkg::word_t got,
                          input hs_data_pkg::word_t exp);
    check_total++;
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
endtask

// delivered tag against arrival order
task automatic check_seq(input string name, input hs_data_pkg::seq_t got,
                         input hs_data_pkg::seq_t exp);
    check_total++;
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_count(input string name, input hs_data_pkg::seq_t got,
                           input hs_data_pkg::seq_t exp);
    check_total++;
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    check_total++;
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic report_failure(input string what);
    other_errors++;
    $display("ERROR %s at %0t", what, $time);
endtask

`endif

// ==== test/tb_hs_cdc_link.sv ====
/* testbench for the link: two clocks, lfsr traffic, queue model and scoreboard */
`timescale 1ns/1ps
`include "hs_consts.svh"

module tb_hs_cdc_link;

    localparam logic [31:0] SEED        = 32'h959f_eddc;
    localparam int          STALL_WORDS = 2 * `HS_FIFO_DEPTH + 1;  // both fifos plus one in flight
    localparam int          SETTLE      = 100;     // tx cycles of steady full
    localparam int          LIMIT       = 2000;    // bound on any wait loop

    logic               clk_i;
    logic               rst_n;
    logic               tx_push_i;
    hs_data_pkg::word_t tx_data_i;
    logic               tx_full_o;
    hs_data_pkg::seq_t  tx_count_o;
    logic               rx_clk_i;
    logic               rx_rst_n;
    logic               rx_pop_i;
    logic               rx_valid_o;
    hs_data_pkg::word_t rx_data_o;
    hs_data_pkg::seq_t  rx_seq_o;
    hs_data_pkg::seq_t  rx_count_o;

    `include "tb_hs_checks.svh"

    hs_data_pkg::word_t model_q [$];    // accepted words, oldest first
    int                 accepted = 0;
    int                 delivered = 0;
    logic [31:0]        tx_lfsr;
    logic [31:0]        rx_lfsr;        // own stream per domain
    logic [31:0]        tx_r;
    logic [31:0]        tx_d;
    logic [31:0]        rx_r;

    hs_cdc_link DUT (.*);

    always #20 clk_i = ~clk_i;      // 40 ns
    always #29 rx_clk_i = ~rx_clk_i; // 58 ns and unrelated to clk_i

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits  = {bits[30:0], state[0]};   // one step per bit
            state = lfsr_step(state);
        end
    endtask

    // entered 2 ns after a tx edge, leaves at the next one
    task automatic tx_cycle(input logic en, input hs_data_pkg::word_t d);
        if (en && !tx_full_o) begin
            model_q.push_back(d);   // full stays put until the edge
            accepted++;
        end
        tx_push_i = en;
        tx_data_i = d;
        @(posedge clk_i);
        #2;
    endtask

    task automatic rx_cycle(input logic en);
        if (en && rx_valid_o) begin
            if (model_q.size() == 0) begin
                report_failure("receive fifo returned a word that was never pushed");
            end else begin
                check_word("rx_data_o", rx_data_o, model_q.pop_front());
                check_seq("rx_seq_o", rx_seq_o, hs_data_pkg::seq_t'(delivered));
            end
            delivered++;
        end
        rx_pop_i = en;
        @(posedge rx_clk_i);
        #2;
    endtask

    // push whenever there is room, stop once full has held for SETTLE cycles
    task automatic fill_to_stall();
        int full_run;
        int cycles;
        full_run = 0;
        cycles   = 0;
        @(posedge clk_i);
        #2;
        while (full_run < SETTLE && cycles < LIMIT) begin
            draw_bits(tx_lfsr, 32, tx_d);
            full_run = tx_full_o ? full_run + 1 : 0;
            tx_cycle(!tx_full_o, tx_d);
            cycles++;
        end
        tx_push_i = 1'b0;
        if (full_run < SETTLE) report_failure("transmit fifo never stalled with pops stopped");
    endtask

    task automatic drain_rx();
        int quiet;
        quiet = 0;
        @(posedge rx_clk_i);
        #2;
        while (delivered < accepted && quiet < LIMIT) begin
            quiet = rx_valid_o ? 0 : quiet + 1;   // cycles since anything arrived
            rx_cycle(1'b1);
        end
        rx_pop_i = 1'b0;
        if (delivered < accepted) report_failure("receive side stopped delivering while draining");
    endtask

    initial begin
        clk_i     = 1'b0;
        rx_clk_i  = 1'b0;
        rst_n     = 1'b0;
        rx_rst_n  = 1'b0;
        tx_push_i = 1'b0;
        tx_data_i = '0;
        rx_pop_i  = 1'b0;
        tx_lfsr   = SEED;
        rx_lfsr   = SEED;
        draw_bits(rx_lfsr, 32, rx_r);   // rx stream one word ahead

        fork
            begin
                repeat (10) @(posedge clk_i);
                #2 rst_n = 1'b1;
            end
            begin
                repeat (10) @(posedge rx_clk_i);
                #2 rx_rst_n = 1'b1;
            end
        join

        // reset values
        @(posedge clk_i);
        #2;
        check_flag("tx_full_o", tx_full_o, 1'b0);
        check_count("tx_count_o", tx_count_o, '0);
        @(posedge rx_clk_i);
        #2;
        check_flag("rx_valid_o", rx_valid_o, 1'b0);
        check_count("rx_count_o", rx_count_o, '0);

        // back-pressure with nothing popped
        fill_to_stall();
        check_count("accepted words at stall", hs_data_pkg::seq_t'(accepted),
                    hs_data_pkg::seq_t'(STALL_WORDS));
        check_count("tx_count_o at stall", tx_count_o, hs_data_pkg::seq_t'(`HS_FIFO_DEPTH + 1));
        check_count("rx_count_o at stall", rx_count_o, hs_data_pkg::seq_t'(`HS_FIFO_DEPTH));
        drain_rx();

        // random traffic in both domains at once
        fork
            begin
                @(posedge clk_i);
                #2;
                repeat (300) begin
                    draw_bits(tx_lfsr, 2, tx_r);
                    draw_bits(tx_lfsr, 32, tx_d);
                    tx_cycle(tx_r[1:0] != 2'b00, tx_d);  // push 3 of 4
                end
                tx_push_i = 1'b0;
            end
            begin
                @(posedge rx_clk_i);
                #2;
                repeat (300) begin
                    draw_bits(rx_lfsr, 1, rx_r);
                    rx_cycle(rx_r[0]);
                end
                rx_pop_i = 1'b0;
            end
        join
        drain_rx();

        // both counters settle on the accepted total
        @(posedge clk_i);
        #2;
        check_count("tx_count_o", tx_count_o, hs_data_pkg::seq_t'(accepted));
        @(posedge rx_clk_i);
        #2;
        check_count("rx_count_o", rx_count_o, hs_data_pkg::seq_t'(accepted));
        check_flag("rx_valid_o", rx_valid_o, 1'b0);    // no extra word behind the last one

        $display("checks %0d, value errors %0d, other errors %0d, words %0d",
                 check_total, value_errors, other_errors, accepted);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== hw/hs_cdc_link.sv ====
/* link top: transmit fifo, four-phase crossing, receive fifo and both transfer counters */
`timescale 1ns/1ps
`include "hs_consts.svh"

module hs_cdc_link (
    // transmit domain
    input  logic               clk_i,
    input  logic               rst_n,
    input  logic               tx_push_i,   // ignored while tx_full_o
    input  hs_data_pkg::word_t tx_data_i,
    output logic               tx_full_o,
    output hs_data_pkg::seq_t  tx_count_o,  // words taken by the handshake

    // receive domain
    input  logic               rx_clk_i,
    input  logic               rx_rst_n,
    input  logic               rx_pop_i,    // ignored while empty
    output logic               rx_valid_o,
    output hs_data_pkg::word_t rx_data_o,
    output hs_data_pkg::seq_t  rx_seq_o,
    output hs_data_pkg::seq_t  rx_count_o   // words landed in rx fifo
);

    hs_data_pkg::word_t     tx_head;        // oldest word waiting to cross
    logic                   tx_head_valid;
    logic                   tx_idle;
    logic                   tx_take;
    logic                   link_req;       // crosses tx -> rx
    hs_data_pkg::word_t     link_data;
    logic                   link_ack;       // crosses rx -> tx
    logic                   rx_push;
    hs_data_pkg::rx_entry_t rx_entry;
    logic                   rx_full;
    hs_data_pkg::seq_t      rx_tag;         // next tag == words received
    hs_data_pkg::rx_entry_t rx_head;

    hs_fifo #(.T(hs_data_pkg::word_t), .DEPTH(`HS_FIFO_DEPTH)) u_tx_fifo (
        .clk_i(clk_i), .rst_n(rst_n),
        .push_i(tx_push_i), .wr_data_i(tx_data_i), .full_o(tx_full_o),
        .rd_take_i(tx_idle), .rd_valid_o(tx_head_valid), .rd_data_o(tx_head),
        .take_o(tx_take)
    );

    hs_xfer_counter #(.W(`HS_SEQ_W)) u_tx_count (
        .clk_i(clk_i), .rst_n(rst_n), .inc_i(tx_take), .count_o(tx_count_o)
    );

    full_handshake_tx #(.DW(`HS_DATA_W)) u_hs_tx (
        .clk_i(clk_i), .rst_n(rst_n), .ack_i(link_ack),
        .req_i(tx_head_valid), .req_data_i(tx_head), .idle_o(tx_idle),
        .req_o(link_req), .req_data_o(link_data)
    );

    full_handshake_rx #(.DW(`HS_DATA_W)) u_hs_rx (
        .clk_i(rx_clk_i), .rst_n(rx_rst_n),
        .req_i(link_req), .req_data_i(link_data),
        .full_i(rx_full), .seq_i(rx_tag),
        .ack_o(link_ack), .push_o(rx_push), .entry_o(rx_entry)
    );

    hs_xfer_counter #(.W(`HS_SEQ_W)) u_rx_count (
        .clk_i(rx_clk_i), .rst_n(rx_rst_n), .inc_i(rx_push), .count_o(rx_tag)
    );

    // take_o left open, no consumer on the receive side
    hs_fifo #(.T(hs_data_pkg::rx_entry_t), .DEPTH(`HS_FIFO_DEPTH)) u_rx_fifo (
        .clk_i(rx_clk_i), .rst_n(rx_rst_n),
        .push_i(rx_push), .wr_data_i(rx_entry), .full_o(rx_full),
        .rd_take_i(rx_pop_i), .rd_valid_o(rx_valid_o), .rd_data_o(rx_head),
        .take_o()
    );

    assign rx_data_o  = rx_head.data;
    assign rx_seq_o   = rx_head.seq;
    assign rx_count_o = rx_tag;

endmodule

// ==== hw/full_handshake_rx.sv ====
/* receive side of the four-phase crossing: req synchronizer, word capture, push and ack */
`timescale 1ns/1ps
`include "hs_consts.svh"

module full_handshake_rx #(
    parameter int DW = `HS_DATA_W   // word width on the link
) (
    input  logic                    clk_i,      // receive clock
    input  logic                    rst_n,      // receive reset

    // from the transmit domain, asynchronous here
    input  logic                    req_i,
    input  logic [DW-1:0]           req_data_i, // stable while req is high

    // receive fifo and tag counter
    input  logic                    full_i,     // no room, hold ack back
    input  hs_data_pkg::seq_t       seq_i,      // tag for the next entry

    output logic                    ack_o,
    output logic                    push_o,     // one cycle per captured word
    output hs_data_pkg::rx_entry_t  entry_o
);

    hs_ctrl_pkg::rx_state_e state;
    hs_ctrl_pkg::rx_state_e state_next;

    logic [`HS_SYNC_STAGES-1:0] req_sync;
    logic                       req;        // req in this clock domain
    logic                       capture;
    logic                       ack;
    logic                       push;
    hs_data_pkg::rx_entry_t     entry;

    assign req = req_sync[`HS_SYNC_STAGES-1];

    // take the word only with room in the fifo, else the link stalls here
    assign capture = (state == hs_ctrl_pkg::RX_IDLE) && req && !full_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            req_sync <= '0;
        end else begin
            req_sync <= {req_sync[`HS_SYNC_STAGES-2:0], req_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            state <= hs_ctrl_pkg::RX_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            hs_ctrl_pkg::RX_IDLE:    if (capture) state_next = hs_ctrl_pkg::RX_ACK;
            hs_ctrl_pkg::RX_ACK:     if (!req) state_next = hs_ctrl_pkg::RX_RELEASE;
            hs_ctrl_pkg::RX_RELEASE: state_next = hs_ctrl_pkg::RX_IDLE;    // ack already low
            default:                 state_next = hs_ctrl_pkg::RX_IDLE;
        endcase
    end

    // ack and push rise together, push lasts one cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            ack  <= 1'b0;
            push <= 1'b0;
        end else begin
            push <= capture;
            if (capture) begin
                ack <= 1'b1;                    // phase 2
            end else if (state == hs_ctrl_pkg::RX_ACK && !req) begin
                ack <= 1'b0;                    // phase 4
            end
        end
    end

    // bus is settled by the time req shows up here
    always_ff @(posedge clk_i) begin
        if (capture) begin
            entry.seq  <= seq_i;
            entry.data <= req_data_i;
        end
    end

    assign ack_o   = ack;
    assign push_o  = push;
    assign entry_o = entry;

endmodule

// ==== hw/full_handshake_tx.sv ====
/* transmit side of the four-phase req/ack crossing, with ack synchronizer */
`timescale 1ns/1ps
`include "hs_consts.svh"

// sequence seen on the wires
//   req up, ack up, req down, ack down
module full_handshake_tx #(
    parameter int DW = `HS_DATA_W   // word width on the link
) (
    input  logic          clk_i,    // transmit clock
    input  logic          rst_n,    // transmit reset

    // from the receive domain, asynchronous here
    input  logic          ack_i,

    // local request, a word is waiting
    input  logic          req_i,
    input  logic [DW-1:0] req_data_i,

    // word taken when idle_o and req_i are both high
    output logic          idle_o,

    // to the receive domain
    output logic          req_o,
    output logic [DW-1:0] req_data_o
);

    hs_ctrl_pkg::tx_state_e state;
    hs_ctrl_pkg::tx_state_e state_next;

    logic [`HS_SYNC_STAGES-1:0] ack_sync;   // ack_i shifted in at bit 0
    logic                       ack;        // ack in this clock domain

    logic          idle;
    logic          req;
    logic [DW-1:0] req_data;

    assign ack = ack_sync[`HS_SYNC_STAGES-1];

    // bring ack over, only the last stage is used
    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            ack_sync <= '0;
        end else begin
            ack_sync <= {ack_sync[`HS_SYNC_STAGES-2:0], ack_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            state <= hs_ctrl_pkg::TX_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            hs_ctrl_pkg::TX_IDLE: begin
                if (req_i) state_next = hs_ctrl_pkg::TX_ASSERT;     // word accepted
            end
            hs_ctrl_pkg::TX_ASSERT: begin
                if (ack) state_next = hs_ctrl_pkg::TX_DEASSERT;     // receiver has it
            end
            hs_ctrl_pkg::TX_DEASSERT: begin
                if (!ack) state_next = hs_ctrl_pkg::TX_IDLE;        // loop closed
            end
            default: state_next = hs_ctrl_pkg::TX_IDLE;
        endcase
    end

    // req and idle flags
    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            idle <= 1'b1;
            req  <= 1'b0;
        end else begin
            case (state)
                hs_ctrl_pkg::TX_IDLE: begin
                    idle <= !req_i;     // busy from the cycle after accept
                    req  <= req_i;
                end
                hs_ctrl_pkg::TX_ASSERT: begin
                    if (ack) req <= 1'b0;   // phase 3
                end
                hs_ctrl_pkg::TX_DEASSERT: begin
                    if (!ack) idle <= 1'b1;
                end
                default: begin
                    idle <= 1'b1;
                    req  <= 1'b0;
                end
            endcase
        end
    end

    // word held steady while req is up, cleared with req
    always_ff @(posedge clk_i) begin
        if (state == hs_ctrl_pkg::TX_IDLE && req_i) begin
            req_data <= req_data_i;
        end else if (state == hs_ctrl_pkg::TX_ASSERT && ack) begin
            req_data <= '0;
        end
    end

    assign idle_o     = idle;
    assign req_o      = req;
    assign req_data_o = req_data;

endmodule

// ==== hw/hs_xfer_counter.sv ====
/* wrapping transfer counter with increment strobe */
`timescale 1ns/1ps
`include "hs_consts.svh"

module hs_xfer_counter #(
    parameter int W = `HS_SEQ_W     // count width, wraps at 2**W
) (
    input  logic         clk_i,
    input  logic         rst_n,
    input  logic         inc_i,     // one completed transfer
    output logic [W-1:0] count_o    // completed so far, mod 2**W
);

    logic [W-1:0] count;

    // on the receive side this is the tag of the next entry
    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            count <= '0;
        end else if (inc_i) begin
            count <= count + 1'b1;  // wraps silently
        end
    end

    assign count_o = count;

endmodule

// ==== hw/hs_fifo.sv ====
/* synchronous fifo, circular buffer with occupancy count and a typed payload */
`timescale 1ns/1ps
`include "hs_consts.svh"

module hs_fifo #(
    parameter type T     = hs_data_pkg::word_t,  // payload type
    parameter int  DEPTH = `HS_FIFO_DEPTH
) (
    input  logic clk_i,
    input  logic rst_n,

    // write side
    input  logic push_i,        // dropped when full
    input  T     wr_data_i,
    output logic full_o,

    // read side
    input  logic rd_take_i,     // gated with empty here
    output logic rd_valid_o,    // head entry present
    output T     rd_data_o,     // head entry
    output logic take_o         // head removed this cycle
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;   // pointer width
    localparam int CW = $clog2(DEPTH + 1);                 // count needs 0..DEPTH

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          empty;
    logic          do_push;
    logic          do_take;

    // step a pointer, wraps also for depths that are not a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full_o  = (count == CW'(DEPTH));
    assign do_push = push_i && !full_o;
    assign do_take = rd_take_i && !empty;

    assign rd_valid_o = !empty;
    assign rd_data_o  = mem[rd_ptr];    // head, valid only with rd_valid_o
    assign take_o     = do_take;        // one pulse per removed entry

    // pointers and occupancy
    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_take) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    // storage, written only on accepted push
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

endmodule

// ==== hw/hs_ctrl_pkg.sv ====
/* state encodings of the transmit and receive handshake machines */
package hs_ctrl_pkg;

    // one-hot transmitter states
    typedef enum logic [2:0] {
        TX_IDLE     = 3'b001,   // free, accepts next word
        TX_ASSERT   = 3'b010,   // req high, wait ack
        TX_DEASSERT = 3'b100    // req low, wait ack to drop
    } tx_state_e;

    // binary receiver states
    typedef enum logic [1:0] {
        RX_IDLE    = 2'b00,     // wait req and room in fifo
        RX_ACK     = 2'b01,     // ack high, wait req low
        RX_RELEASE = 2'b10      // ack low again, one guard cycle
    } rx_state_e;

endpackage

// ==== hw/hs_data_pkg.sv ====
/* payload types of the link: data word, sequence tag, receive fifo entry */
`include "hs_consts.svh"

package hs_data_pkg;

    // one word per four-phase transfer
    typedef logic [`HS_DATA_W-1:0] word_t;

    // receive order tag, also the transfer count value
    typedef logic [`HS_SEQ_W-1:0] seq_t;

    // entry of the receive fifo
    // tag sits in the upper bits
    typedef struct packed {
        seq_t  seq;     // order of arrival, wraps
        word_t data;    // word as captured off the link
    } rx_entry_t;

endpackage

// ==== hw/hs_consts.svh ====
/* width, depth and synchronizer length macros shared by the link RTL */
`ifndef HS_CONSTS_SVH
`define HS_CONSTS_SVH

// payload word carried per handshake
`define HS_DATA_W 32

// sequence tag and transfer counter width
`define HS_SEQ_W 8

`define HS_FIFO_DEPTH 4    // entries per fifo, both domains

// flops in each req / ack synchronizer
`define HS_SYNC_STAGES 2

`endif
